// File: periph_top.f
rtl/soc_periph_pkg.sv
rtl/apb_periph_decode.sv
rtl/cfg_regs.sv
rtl/mtimer.sv
rtl/intc.sv
rtl/periph_top.sv
bench/periph_top_tb.sv

// File: bench/periph_top_tb.sv
`timescale 1ns/1ps

module periph_top_tb;

    import soc_periph_pkg::*;

    localparam int TICK_DIV    = 4;
    localparam int NUM_EXT_IRQ = 32;
    localparam int CLK_PERIOD  = 10;
    // about 50 transfers of 2 cycles plus irq and timer waits leave a wide margin
    localparam int TEST_CYCLES = 2000;

    localparam logic [31:0] CFG_BASE  = 32'h0000_0000;
    localparam logic [31:0] INTC_BASE = 32'h1 << INTC_SEL_BIT;

    logic                   clk;
    logic                   rst_n;
    apb_req_t               apb_req;
    apb_rsp_t               apb_rsp;
    logic [NUM_EXT_IRQ-1:0] ints;
    logic                   core_rstn;
    irq_t                   irq;

    int          errors;
    int          checks;
    logic [31:0] rng_state;

    // register model state
    logic        core_run_sh;
    logic [31:0] scratch_sh;
    logic        msip_sh;
    logic [31:0] eie_sh;
    logic [63:0] mtimecmp_sh;

    periph_top #(
        .TICK_DIV    ( TICK_DIV    ),
        .NUM_EXT_IRQ ( NUM_EXT_IRQ )
    ) DUT (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .apb_req   ( apb_req   ),
        .apb_rsp   ( apb_rsp   ),
        .ints      ( ints      ),
        .core_rstn ( core_rstn ),
        .irq       ( irq       )
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [31:0] expected_read(input logic [31:0] addr);
        if (addr[INTC_SEL_BIT]) begin
            case (addr[REG_OFS_W-1:0])
                INTC_MSIP:        return {31'b0, msip_sh};
                INTC_MTIMECMP_LO: return mtimecmp_sh[31:0];
                INTC_MTIMECMP_HI: return mtimecmp_sh[63:32];
                INTC_EIE:         return eie_sh;
                INTC_EIP:         return ints;
                default:          return 32'h0;
            endcase
        end
        case (addr[REG_OFS_W-1:0])
            CFG_CORE_CTRL: return {31'b0, core_run_sh};
            CFG_SCRATCH:   return scratch_sh;
            CFG_ID:        return CFG_ID_VALUE;
            default:       return 32'h0;
        endcase
    endfunction

    task automatic model_write(input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] strb);
        if (addr[INTC_SEL_BIT]) begin
            // intc writes vanish while the core is held in reset
            if (core_run_sh) begin
                case (addr[REG_OFS_W-1:0])
                    INTC_MSIP:        msip_sh = data[0];
                    INTC_EIE:         eie_sh = data;
                    INTC_MTIMECMP_LO: mtimecmp_sh[31:0] = data;
                    INTC_MTIMECMP_HI: mtimecmp_sh[63:32] = data;
                    default:          ;
                endcase
            end
        end else if (addr[REG_OFS_W-1:0] == CFG_CORE_CTRL && strb[0]) begin
            core_run_sh = data[0];
        end else if (addr[REG_OFS_W-1:0] == CFG_SCRATCH) begin
            for (int b = 0; b < 4; b++) begin
                if (strb[b]) scratch_sh[8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic after_edge();
        @(posedge clk);
        #1;
    endtask

    // called 1 ns after a rising edge and returns 1 ns after the completing edge
    task automatic apb_transfer(input logic [31:0] addr, input logic [31:0] wdata,
                                input logic [3:0] strb, input logic write,
                                output logic [31:0] rdata, output logic err);
        apb_req.psel    = 1'b1;
        apb_req.penable = 1'b0;
        apb_req.paddr   = addr;
        apb_req.pwrite  = write;
        apb_req.pstrb   = strb;
        apb_req.pwdata  = wdata;
        after_edge();
        apb_req.penable = 1'b1;
        @(negedge clk);
        // zero wait states, so the first access cycle completes
        check("apb pready", 32'h1, apb_rsp.pready);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        after_edge();
        apb_req.psel    = 1'b0;
        apb_req.penable = 1'b0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [31:0] data,
                             input logic [3:0] strb);
        logic [31:0] unused_rdata;
        logic        err;
        apb_transfer(addr, data, strb, 1'b1, unused_rdata, err);
        model_write(addr, data, strb);
    endtask

    task automatic apb_read(input logic [31:0] addr, output logic [31:0] data,
                            output logic err);
        apb_transfer(addr, 32'h0, 4'h0, 1'b0, data, err);
    endtask

    task automatic read_expect(input string name, input logic [31:0] addr);
        logic [31:0] data;
        logic        err;
        apb_read(addr, data, err);
        check(name, expected_read(addr), data);
        check({name, " pslverr"}, 32'h0, err);
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] t0;
        logic [31:0] t1;
        logic        err;
        clk         = 1'b0;
        rst_n       = 1'b0;
        apb_req     = '0;
        ints        = '0;
        rng_state   = 32'd7761;
        errors      = 0;
        checks      = 0;
        core_run_sh = 1'b0;
        scratch_sh  = '0;
        msip_sh     = 1'b0;
        eie_sh      = '0;
        mtimecmp_sh = '1;
        repeat (3) @(posedge clk);
        #1;
        rst_n = 1'b1;
        after_edge();

        check("reset core_rstn", 32'h0, core_rstn);
        check("reset irq", 32'h0, irq);
        read_expect("reset core_ctrl", CFG_BASE | CFG_CORE_CTRL);
        read_expect("cfg id", CFG_BASE | CFG_ID);
        apb_write(INTC_BASE | INTC_EIE, 32'hffff_ffff, 4'hf);
        read_expect("eie while core held", INTC_BASE | INTC_EIE);
        read_expect("mtimecmp while core held", INTC_BASE | INTC_MTIMECMP_LO);

        repeat (8) begin
            r = next_random();
            apb_write(CFG_BASE | CFG_SCRATCH, next_random(), r[3:0]);
            read_expect("scratch merge", CFG_BASE | CFG_SCRATCH);
        end
        apb_write(CFG_BASE | CFG_ID, next_random(), 4'hf);
        read_expect("cfg id after write", CFG_BASE | CFG_ID);

        apb_write(CFG_BASE | CFG_CORE_CTRL, 32'h1, 4'hf);
        check("core_rstn before release", 32'h0, core_rstn);
        after_edge();
        check("core_rstn released", 32'h1, core_rstn);
        apb_write(INTC_BASE | INTC_EIE, next_random(), 4'hf);
        read_expect("eie mask", INTC_BASE | INTC_EIE);

        apb_write(INTC_BASE | INTC_MSIP, 32'h1, 4'hf);
        check("msip lag", 32'h0, irq.msip);
        after_edge();
        check("msip set", 32'h1, irq.msip);
        apb_write(INTC_BASE | INTC_MSIP, 32'h0, 4'hf);
        after_edge();
        check("msip clear", 32'h0, irq.msip);

        for (int i = 0; i < 8; i++) begin
            r = next_random();
            // every other pattern avoids the enabled lines
            ints = (i % 2) ? (r & ~eie_sh) : r;
            after_edge();
            after_edge();
            check("meip", {31'b0, |(ints & eie_sh)}, irq.meip);
            read_expect("eip", INTC_BASE | INTC_EIP);
        end
        ints = '0;

        apb_write(INTC_BASE | INTC_MTIMECMP_LO, 32'h0, 4'hf);
        apb_write(INTC_BASE | INTC_MTIMECMP_HI, 32'h0, 4'hf);
        after_edge();
        after_edge();
        check("mtip set", 32'h1, irq.mtip);
        read_expect("mtimecmp hi", INTC_BASE | INTC_MTIMECMP_HI);
        apb_write(INTC_BASE | INTC_MTIMECMP_LO, 32'hffff_ffff, 4'hf);
        apb_write(INTC_BASE | INTC_MTIMECMP_HI, 32'hffff_ffff, 4'hf);
        after_edge();
        after_edge();
        check("mtip clear", 32'h0, irq.mtip);
        apb_read(INTC_BASE | INTC_MTIME_LO, t0, err);
        // second sample lands exactly two prescaler periods later
        repeat (2 * TICK_DIV - 2) after_edge();
        apb_read(INTC_BASE | INTC_MTIME_LO, t1, err);
        check("mtime advance", 32'd2, t1 - t0);

        apb_read(CFG_BASE | 32'h00C, r, err);
        check("cfg unmapped pslverr", 32'h1, err);
        check("cfg unmapped prdata", 32'h0, r);
        apb_read(INTC_BASE | 32'h01C, r, err);
        check("intc unmapped pslverr", 32'h1, err);
        check("intc unmapped prdata", 32'h0, r);

        $display("errors: %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(TEST_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d clock cycles", TEST_CYCLES);
        $display("errors: %0d in %0d checks", errors, checks);
        $display("Test failed");
        $finish;
    end

endmodule

// File: rtl/periph_top.sv
`timescale 1ns/1ps

module periph_top #(
    parameter int TICK_DIV    = 4,
    parameter int NUM_EXT_IRQ = 32
) (
    input  logic                     clk,
    input  logic                     rst_n,

    input  soc_periph_pkg::apb_req_t apb_req,
    output soc_periph_pkg::apb_rsp_t apb_rsp,

    input  logic [NUM_EXT_IRQ-1:0]   ints,
    output logic                     core_rstn,
    output soc_periph_pkg::irq_t     irq
);

    import soc_periph_pkg::*;

    apb_req_t cfg_req;
    apb_rsp_t cfg_rsp;
    apb_req_t intc_req;
    apb_rsp_t intc_rsp;

    apb_periph_decode u_decode (
        .req      ( apb_req  ),
        .rsp      ( apb_rsp  ),
        .cfg_req  ( cfg_req  ),
        .cfg_rsp  ( cfg_rsp  ),
        .intc_req ( intc_req ),
        .intc_rsp ( intc_rsp )
    );

    cfg_regs u_cfg_regs (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .req       ( cfg_req   ),
        .rsp       ( cfg_rsp   ),
        .core_rstn ( core_rstn )
    );

    // interrupt block lives in the core reset domain
    intc #(
        .TICK_DIV    ( TICK_DIV    ),
        .NUM_EXT_IRQ ( NUM_EXT_IRQ )
    ) u_intc (
        .clk   ( clk       ),
        .rst_n ( core_rstn ),
        .req   ( intc_req  ),
        .rsp   ( intc_rsp  ),
        .ints  ( ints      ),
        .irq   ( irq       )
    );

endmodule

// File: rtl/intc.sv
`timescale 1ns/1ps

module intc #(
    parameter int TICK_DIV    = 4,
    parameter int NUM_EXT_IRQ = 32
) (
    input  logic                     clk,
    input  logic                     rst_n,

    input  soc_periph_pkg::apb_req_t req,
    output soc_periph_pkg::apb_rsp_t rsp,

    input  logic [NUM_EXT_IRQ-1:0]   ints,
    output soc_periph_pkg::irq_t     irq
);

    import soc_periph_pkg::*;

    intc_reg_e              reg_sel;
    logic                   access;
    logic                   wr_en;
    logic                   hit;
    logic [31:0]            rdata;
    logic                   msip_bit;
    logic [NUM_EXT_IRQ-1:0] eie;
    logic                   msip_q;
    logic                   meip_q;
    logic                   timer_irq;
    logic [63:0]            mtime;
    logic [63:0]            mtimecmp;

    assign reg_sel = intc_reg_e'(req.paddr[REG_OFS_W-1:0]);
    assign access  = req.psel & req.penable;
    assign wr_en   = access & req.pwrite & hit;

    always_comb begin
        hit   = 1'b1;
        rdata = '0;
        case (reg_sel)
            INTC_MSIP:        rdata = {31'b0, msip_bit};
            INTC_MTIMECMP_LO: rdata = mtimecmp[31:0];
            INTC_MTIMECMP_HI: rdata = mtimecmp[63:32];
            INTC_MTIME_LO:    rdata = mtime[31:0];
            INTC_MTIME_HI:    rdata = mtime[63:32];
            INTC_EIE:         rdata = 32'(eie);
            INTC_EIP:         rdata = 32'(ints);
            default:          hit   = 1'b0;
        endcase
    end

    // mtime and EIP are read only, writes there just complete
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            msip_bit <= 1'b0;
            eie      <= '0;
        end else if (wr_en) begin
            case (reg_sel)
                INTC_MSIP: msip_bit <= req.pwdata[0];
                INTC_EIE:  eie      <= req.pwdata[NUM_EXT_IRQ-1:0];
                default:   ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            msip_q <= 1'b0;
            meip_q <= 1'b0;
        end else begin
            msip_q <= msip_bit;
            meip_q <= |(ints & eie);
        end
    end

    mtimer #(
        .TICK_DIV ( TICK_DIV )
    ) u_mtimer (
        .clk       ( clk                                   ),
        .rst_n     ( rst_n                                 ),
        .cmp_wr_lo ( wr_en && (reg_sel == INTC_MTIMECMP_LO) ),
        .cmp_wr_hi ( wr_en && (reg_sel == INTC_MTIMECMP_HI) ),
        .wdata     ( req.pwdata                            ),
        .mtime     ( mtime                                 ),
        .mtimecmp  ( mtimecmp                              ),
        .mtip      ( timer_irq                             )
    );

    assign irq = '{msip: msip_q, mtip: timer_irq, meip: meip_q};
    assign rsp = '{prdata: rdata, pslverr: access & ~hit, pready: 1'b1};

    // zero wait states, even while the core is held in reset
    assert property (@(posedge clk) req.psel && req.penable |-> rsp.pready)
        else $error("intc stalled an access cycle");

endmodule

// File: rtl/mtimer.sv
`timescale 1ns/1ps

module mtimer #(
    parameter int TICK_DIV = 4
) (
    input  logic        clk,
    input  logic        rst_n,

    input  logic        cmp_wr_lo,
    input  logic        cmp_wr_hi,
    input  logic [31:0] wdata,

    output logic [63:0] mtime,
    output logic [63:0] mtimecmp,
    output logic        mtip
);

    localparam int PW = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

    logic [PW-1:0] pre_cnt;
    logic          tick;

    assign tick = (pre_cnt == PW'(TICK_DIV - 1));

    // prescaler, one tick every TICK_DIV cycles
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pre_cnt <= '0;
        end else if (tick) begin
            pre_cnt <= '0;
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtime <= '0;
        end else if (tick) begin
            mtime <= mtime + 64'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtimecmp <= '1;
        end else begin
            if (cmp_wr_lo) begin
                mtimecmp[31:0] <= wdata;
            end
            if (cmp_wr_hi) begin
                mtimecmp[63:32] <= wdata;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mtip <= 1'b0;
        end else begin
            mtip <= (mtime >= mtimecmp);
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) mtime >= $past(mtime))
        else $error("mtime went backwards");

endmodule

// File: rtl/cfg_regs.sv
`timescale 1ns/1ps

module cfg_regs (
    input  logic                     clk,
    input  logic                     rst_n,

    input  soc_periph_pkg::apb_req_t req,
    output soc_periph_pkg::apb_rsp_t rsp,

    output logic                     core_rstn
);

    import soc_periph_pkg::*;

    cfg_reg_e    reg_sel;
    logic        access;
    logic        wr_en;
    logic        hit;
    logic [31:0] rdata;
    logic        core_run;
    logic [31:0] scratch;

    assign reg_sel = cfg_reg_e'(req.paddr[REG_OFS_W-1:0]);
    assign access  = req.psel & req.penable;
    assign wr_en   = access & req.pwrite & hit;

    always_comb begin
        hit   = 1'b1;
        rdata = '0;
        case (reg_sel)
            CFG_CORE_CTRL: rdata = {31'b0, core_run};
            CFG_SCRATCH:   rdata = scratch;
            CFG_ID:        rdata = CFG_ID_VALUE;
            default:       hit   = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            core_run <= 1'b0;
            scratch  <= '0;
        end else if (wr_en) begin
            if (reg_sel == CFG_CORE_CTRL && req.pstrb[0]) begin
                core_run <= req.pwdata[0];
            end
            if (reg_sel == CFG_SCRATCH) begin
                for (int b = 0; b < 4; b++) begin
                    if (req.pstrb[b]) begin
                        scratch[8*b +: 8] <= req.pwdata[8*b +: 8];
                    end
                end
            end
        end
    end

    // core reset release lags core_run by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            core_rstn <= 1'b0;
        end else begin
            core_rstn <= core_run;
        end
    end

    assign rsp = '{prdata: rdata, pslverr: access & ~hit, pready: 1'b1};

    assert property (@(posedge clk) !rst_n |-> !core_rstn)
        else $error("core reset released while system reset is held");

endmodule

// File: rtl/apb_periph_decode.sv
`timescale 1ns/1ps

module apb_periph_decode (
    input  soc_periph_pkg::apb_req_t req,
    output soc_periph_pkg::apb_rsp_t rsp,

    output soc_periph_pkg::apb_req_t cfg_req,
    input  soc_periph_pkg::apb_rsp_t cfg_rsp,

    output soc_periph_pkg::apb_req_t intc_req,
    input  soc_periph_pkg::apb_rsp_t intc_rsp
);

    import soc_periph_pkg::*;

    logic intc_hit;

    assign intc_hit = req.paddr[INTC_SEL_BIT];

    always_comb begin
        // address, strobes and data go to both sides unchanged
        cfg_req          = req;
        cfg_req.psel     = req.psel & ~intc_hit;
        cfg_req.penable  = req.penable & ~intc_hit;

        intc_req         = req;
        intc_req.psel    = req.psel & intc_hit;
        intc_req.penable = req.penable & intc_hit;

        // response back from whichever slave owns the address
        rsp = intc_hit ? intc_rsp : cfg_rsp;

        assert final ((cfg_req.psel & intc_req.psel) !== 1'b1)
            else $error("both peripheral slaves selected at once");
    end

endmodule

// File: rtl/soc_periph_pkg.sv
package soc_periph_pkg;

    // low address bits decoded inside each slave
    localparam int REG_OFS_W = 12;

    // address bit that steers a transfer to the interrupt controller
    localparam int INTC_SEL_BIT = 27;

    localparam logic [31:0] CFG_ID_VALUE = 32'h5052_0100;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic [31:0] paddr;
        logic        pwrite;
        logic [3:0]  pstrb;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pslverr;
        logic        pready;
    } apb_rsp_t;

    typedef struct packed {
        logic msip;
        logic mtip;
        logic meip;
    } irq_t;

    typedef enum logic [REG_OFS_W-1:0] {
        CFG_CORE_CTRL = 12'h000,
        CFG_SCRATCH   = 12'h004,
        CFG_ID        = 12'h008
    } cfg_reg_e;

    // CLINT-style layout, timer halves little end first
    typedef enum logic [REG_OFS_W-1:0] {
        INTC_MSIP        = 12'h000,
        INTC_MTIMECMP_LO = 12'h004,
        INTC_MTIMECMP_HI = 12'h008,
        INTC_MTIME_LO    = 12'h00C,
        INTC_MTIME_HI    = 12'h010,
        INTC_EIE         = 12'h014,
        INTC_EIP         = 12'h018
    } intc_reg_e;

endpackage
